/* src/scaler_pkg.sv */
`default_nettype none

package scaler_pkg;

    // --------------------
    // sizes
    // --------------------

    // pixels per source line, kept small for simulation
    localparam int LINE_PIXELS = 16;
    localparam int PIX_ADDR_W = $clog2(LINE_PIXELS);

    // three source lines in, five display lines out
    localparam int LINES_PER_GROUP = 3;
    localparam int OUT_LINES_PER_GROUP = 5;

    // groups A and B, one fills while the other is read
    localparam int NUM_GROUPS = 2;

    localparam int LINE_CNT_W = 16;

    // --------------------
    // apb address map
    // --------------------

    localparam logic [3:0] ADDR_CTRL = 4'h0;
    localparam logic [3:0] ADDR_STATUS = 4'h4;
    localparam logic [3:0] ADDR_LINE_COUNT = 4'h8;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_BLEND_BIT = 1;
    localparam int STATUS_OVERFLOW_BIT = 0;

    // --------------------
    // types
    // --------------------

    // palette colour, blue in the top bits
    typedef struct packed {
        logic [1:0] b;
        logic [2:0] g;
        logic [2:0] r;
    } color233_t;

    // display colour
    typedef struct packed {
        logic [4:0] b;
        logic [4:0] g;
        logic [4:0] r;
    } color555_t;

    // source stream beat, no handshake
    typedef struct packed {
        logic      valid;
        logic      sol;
        logic      sof;
        color233_t color;
    } src_pix_t;

    // one pixel column across the three lines of a group
    typedef struct packed {
        color233_t [LINES_PER_GROUP-1:0] ln;
    } line_triple_t;

    // store write command
    typedef struct packed {
        logic                  en;
        logic                  group;
        logic [1:0]            line;
        logic [PIX_ADDR_W-1:0] addr;
        color233_t             color;
    } wr_req_t;

    typedef struct packed {
        logic      sol;
        color555_t color;
    } out_pix_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    typedef struct packed {
        logic enable;
        logic blend;
    } ctrl_t;

endpackage

`default_nettype wire

/* src/scaler_apb_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module scaler_apb_regs import scaler_pkg::*; (
    input  logic     clk24,
    input  logic     rst_n_i,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,
    output ctrl_t    ctrl_o,
    input  logic     overflow_i,
    input  logic     line_start_i
);

    logic acc;
    logic wr_acc;
    logic hit_ctrl;
    logic hit_status;
    logic hit_count;
    logic mapped;

    ctrl_t                 ctrl_q;
    logic                  ovf_q;
    logic [LINE_CNT_W-1:0] line_cnt;

    // access phase of a transfer
    assign acc = apb_req_i.psel && apb_req_i.penable;
    assign wr_acc = acc && apb_req_i.pwrite;

    // address decode
    assign hit_ctrl = (apb_req_i.paddr == ADDR_CTRL);
    assign hit_status = (apb_req_i.paddr == ADDR_STATUS);
    assign hit_count = (apb_req_i.paddr == ADDR_LINE_COUNT);
    assign mapped = hit_ctrl || hit_status || hit_count;

    // --------------------
    // read side
    // --------------------

    always_comb
    begin
        apb_rsp_o = '0;
        // never any wait states
        apb_rsp_o.pready = 1'b1;
        apb_rsp_o.pslverr = acc && !mapped;
        if (acc && !apb_req_i.pwrite)
        begin
            if (hit_ctrl)
            begin
                apb_rsp_o.prdata[CTRL_ENABLE_BIT] = ctrl_q.enable;
                apb_rsp_o.prdata[CTRL_BLEND_BIT] = ctrl_q.blend;
            end
            if (hit_status)
                apb_rsp_o.prdata[STATUS_OVERFLOW_BIT] = ovf_q;
            if (hit_count)
                apb_rsp_o.prdata[LINE_CNT_W-1:0] = line_cnt;
        end
    end

    // --------------------
    // registers
    // --------------------

    always_ff @(posedge clk24 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            // scaler runs with blending out of reset
            ctrl_q <= '{enable: 1'b1, blend: 1'b1};
            ovf_q <= 1'b0;
            line_cnt <= '0;
        end
        else
        begin
            if (wr_acc && hit_ctrl)
            begin
                ctrl_q.enable <= apb_req_i.pwdata[CTRL_ENABLE_BIT];
                ctrl_q.blend <= apb_req_i.pwdata[CTRL_BLEND_BIT];
            end
            // sticky, a new event beats the clear
            if (overflow_i)
                ovf_q <= 1'b1;
            else if (wr_acc && hit_status && apb_req_i.pwdata[STATUS_OVERFLOW_BIT])
                ovf_q <= 1'b0;
            // counts accepted line starts, wraps
            if (line_start_i)
                line_cnt <= line_cnt + 1'b1;
        end
    end

    assign ctrl_o = ctrl_q;

    // access phase only ever follows a selected setup phase
    a_penable_needs_psel: assert property (@(posedge clk24) disable iff (!rst_n_i)
        apb_req_i.penable |-> apb_req_i.psel);

endmodule

`default_nettype wire

/* src/line_writer.sv */
`timescale 1ns/10ps
`default_nettype none

module line_writer import scaler_pkg::*; (
    input  logic     clk24,
    input  logic     rst_n_i,
    input  ctrl_t    ctrl_i,
    input  src_pix_t src_pix_i,
    output wr_req_t  wr_o,
    output logic     group_done_o,
    output logic     done_group_o,
    input  logic     group_free_i,
    input  logic     free_group_i,
    output logic     overflow_o
);

    logic [PIX_ADDR_W-1:0] pix_cnt;
    logic [1:0]            line_idx;
    logic                  wr_group;
    logic                  in_line;
    logic                  dropping;
    logic [NUM_GROUPS-1:0] full_q;

    logic       take;
    logic       start;
    logic       cur_group;
    logic [1:0] cur_line;
    logic       drop_start;
    logic       drop_now;
    logic       line_end;
    logic       grp_end;

    // source beats are only looked at while enabled
    assign take = ctrl_i.enable && src_pix_i.valid;
    assign start = take && src_pix_i.sol;

    // sof snaps back to group A, line 0
    assign cur_group = (start && src_pix_i.sof) ? 1'b0 : wr_group;
    assign cur_line = (start && src_pix_i.sof) ? 2'd0 : line_idx;

    // group still owned by the blender, give up on all three lines
    assign drop_start = start && (cur_line == 2'd0) && full_q[cur_group];
    assign drop_now = start ? ((cur_line == 2'd0) ? full_q[cur_group] : dropping) : dropping;

    assign line_end = take && in_line && !src_pix_i.sol
                      && (pix_cnt == PIX_ADDR_W'(LINE_PIXELS - 1));
    assign grp_end = line_end && (line_idx == 2'(LINES_PER_GROUP - 1));

    // write goes straight to the store this cycle
    always_comb
    begin
        wr_o.en = take && (start || in_line) && !drop_now;
        wr_o.group = cur_group;
        wr_o.line = cur_line;
        wr_o.addr = start ? '0 : pix_cnt;
        wr_o.color = src_pix_i.color;
    end

    always_ff @(posedge clk24 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            pix_cnt <= '0;
            line_idx <= '0;
            wr_group <= 1'b0;
            in_line <= 1'b0;
            dropping <= 1'b0;
            full_q <= '0;
            group_done_o <= 1'b0;
            done_group_o <= 1'b0;
            overflow_o <= 1'b0;
        end
        else
        begin
            group_done_o <= 1'b0;
            overflow_o <= drop_start;
            if (start)
            begin
                // pixel 0 written above, next one is 1
                in_line <= 1'b1;
                pix_cnt <= PIX_ADDR_W'(1);
                wr_group <= cur_group;
                line_idx <= cur_line;
                dropping <= drop_now;
            end
            else if (take && in_line)
            begin
                pix_cnt <= pix_cnt + 1'b1;
                if (line_end)
                begin
                    in_line <= 1'b0;
                    if (grp_end)
                    begin
                        line_idx <= 2'd0;
                        // after a drop the same group is tried again
                        dropping <= 1'b0;
                        if (!dropping)
                        begin
                            wr_group <= ~wr_group;
                            group_done_o <= 1'b1;
                            done_group_o <= wr_group;
                        end
                    end
                    else
                        line_idx <= line_idx + 1'b1;
                end
            end
            // full from completion until the blender lets go
            if (group_free_i)
                full_q[free_group_i] <= 1'b0;
            if (grp_end && !dropping)
                full_q[wr_group] <= 1'b1;
        end
    end

    // never overwrite a group queued or being read by the blender
    a_no_write_full: assert property (@(posedge clk24) disable iff (!rst_n_i)
        wr_o.en |-> !full_q[wr_o.group]);

    // lines must arrive complete
    a_sol_after_line: assert property (@(posedge clk24) disable iff (!rst_n_i)
        start |-> !in_line);

endmodule

`default_nettype wire

/* src/line_store.sv */
`timescale 1ns/10ps
`default_nettype none

module line_store import scaler_pkg::*; (
    input  logic                  clk24,
    input  wr_req_t               wr_i,
    input  logic                  rd_group_i,
    input  logic [PIX_ADDR_W-1:0] rd_addr_i,
    output line_triple_t          rd_data_o
);

    // six line memories, A0..A2 and B0..B2
    color233_t mem [NUM_GROUPS][LINES_PER_GROUP][LINE_PIXELS];

    // --------------------
    // write port
    // --------------------

    // one pixel per cycle from the writer
    always_ff @(posedge clk24)
    begin
        if (wr_i.en)
            mem[wr_i.group][wr_i.line][wr_i.addr] <= wr_i.color;
    end

    // --------------------
    // read port
    // --------------------

    // same column of all three lines of a group, registered
    always_ff @(posedge clk24)
    begin
        for (int k = 0; k < LINES_PER_GROUP; k++)
        begin
            rd_data_o.ln[k] <= mem[rd_group_i][k][rd_addr_i];
        end
    end

endmodule

`default_nettype wire

/* src/line_blender.sv */
`timescale 1ns/10ps
`default_nettype none

module line_blender import scaler_pkg::*; (
    input  logic                  clk24,
    input  logic                  rst_n_i,
    input  ctrl_t                 ctrl_i,
    input  logic                  group_done_i,
    input  logic                  done_group_i,
    output logic                  group_free_o,
    output logic                  free_group_o,
    output logic                  rd_group_o,
    output logic [PIX_ADDR_W-1:0] rd_addr_o,
    input  line_triple_t          rd_data_i,
    output out_pix_t              out_pix_o,
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output logic                  line_start_o
);

    // per pixel tag carried down the pipe
    typedef struct packed {
        logic sol;
        logic last;
        logic grp;
    } tag_t;

    // channel sums, blue keeps 4 bits
    typedef struct packed {
        logic [3:0] b;
        logic [4:0] g;
        logic [4:0] r;
    } sum_t;

    logic [1:0]            q_cnt;
    logic                  q0;
    logic                  q1;
    logic [PIX_ADDR_W-1:0] pix;
    logic [2:0]            oline;
    logic                  adv;
    logic                  issue;
    logic                  last_issue;
    logic                  pop;

    logic                  v1;
    logic                  v2;
    logic                  v3;
    tag_t                  t1;
    tag_t                  t2;
    tag_t                  t3;
    tag_t                  t4;
    logic [PIX_ADDR_W-1:0] s1_addr;
    logic [2:0]            s1_line;
    logic [3:0][1:0]       sel;
    color233_t             ma;
    color233_t             mb;
    color233_t             mc;
    color233_t             md;
    color233_t             c2;
    color233_t             d2;
    color233_t             d3;
    sum_t                  s2;
    sum_t                  s3;
    sum_t                  s4;

    // whole pipe moves only when the sink takes
    assign adv = out_ready_i;

    // --------------------
    // group queue and read sequencing
    // --------------------

    assign issue = (q_cnt != 2'd0) && ctrl_i.enable;
    assign last_issue = (pix == PIX_ADDR_W'(LINE_PIXELS - 1))
                        && (oline == 3'(OUT_LINES_PER_GROUP - 1));
    assign pop = adv && issue && last_issue;

    // on a stall re-read the column held in the read stage
    assign rd_group_o = adv ? q0 : t1.grp;
    assign rd_addr_o = adv ? pix : s1_addr;

    always_ff @(posedge clk24 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            q_cnt <= '0;
            q0 <= 1'b0;
            q1 <= 1'b0;
            pix <= '0;
            oline <= '0;
        end
        else
        begin
            // two entry fifo of finished groups
            if (pop)
                q0 <= q1;
            if (group_done_i)
            begin
                if (q_cnt == 2'd0 || (q_cnt == 2'd1 && pop))
                    q0 <= done_group_i;
                else
                    q1 <= done_group_i;
            end
            q_cnt <= q_cnt + 2'(group_done_i) - 2'(pop);
            // five passes over the group per entry
            if (adv && issue)
            begin
                if (pix == PIX_ADDR_W'(LINE_PIXELS - 1))
                begin
                    pix <= '0;
                    oline <= last_issue ? 3'd0 : oline + 3'd1;
                end
                else
                    pix <= pix + 1'b1;
            end
        end
    end

    // --------------------
    // line table
    // --------------------

    // stored line for each mix input, packed as d, c, b, a
    always_comb
    begin
        if (ctrl_i.blend)
        begin
            case (s1_line)
                3'd0: sel = {2'd0, 2'd0, 2'd0, 2'd0};
                3'd1: sel = {2'd1, 2'd0, 2'd0, 2'd0};
                3'd2: sel = {2'd1, 2'd1, 2'd1, 2'd1};
                3'd3: sel = {2'd2, 2'd2, 2'd1, 2'd1};
                default: sel = {2'd2, 2'd2, 2'd2, 2'd2};
            endcase
        end
        else
        begin
            // plain repeat 1, 2, 2, 3, 3
            case (s1_line)
                3'd0: sel = {2'd0, 2'd0, 2'd0, 2'd0};
                3'd1, 3'd2: sel = {2'd1, 2'd1, 2'd1, 2'd1};
                default: sel = {2'd2, 2'd2, 2'd2, 2'd2};
            endcase
        end
    end

    assign ma = rd_data_i.ln[sel[0]];
    assign mb = rd_data_i.ln[sel[1]];
    assign mc = rd_data_i.ln[sel[2]];
    assign md = rd_data_i.ln[sel[3]];

    // --------------------
    // mix pipeline
    // --------------------

    always_ff @(posedge clk24 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
            out_valid_o <= 1'b0;
        end
        else if (adv)
        begin
            v1 <= issue;
            v2 <= v1;
            v3 <= v2;
            out_valid_o <= v3;
        end
    end

    always_ff @(posedge clk24)
    begin
        if (adv)
        begin
            // read stage
            t1 <= '{sol: (pix == '0), last: last_issue, grp: q0};
            s1_addr <= pix;
            s1_line <= oline;
            // a + b
            t2 <= t1;
            s2.r <= 5'(ma.r) + 5'(mb.r);
            s2.g <= 5'(ma.g) + 5'(mb.g);
            s2.b <= 4'(ma.b) + 4'(mb.b);
            c2 <= mc;
            d2 <= md;
            // plus c
            t3 <= t2;
            s3.r <= s2.r + 5'(c2.r);
            s3.g <= s2.g + 5'(c2.g);
            s3.b <= s2.b + 4'(c2.b);
            d3 <= d2;
            // plus d, plus 1 for rounding
            t4 <= t3;
            s4.r <= s3.r + 5'(d3.r) + 5'd1;
            s4.g <= s3.g + 5'(d3.g) + 5'd1;
            s4.b <= s3.b + 4'(d3.b) + 4'd1;
        end
    end

    // bgr555 pack, blue lsb stays 0
    always_comb
    begin
        out_pix_o.sol = t4.sol;
        out_pix_o.color.r = s4.r;
        out_pix_o.color.g = s4.g;
        out_pix_o.color.b = {s4.b, 1'b0};
    end

    // group returned once its final pixel is taken
    assign group_free_o = out_valid_o && out_ready_i && t4.last;
    assign free_group_o = t4.grp;
    assign line_start_o = out_valid_o && out_ready_i && t4.sol;

    // held pixel must not change under back-pressure
    a_out_stable: assert property (@(posedge clk24) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_pix_o));

endmodule

`default_nettype wire

/* src/scaler_top.sv */
`timescale 1ns/10ps
`default_nettype none

module scaler_top import scaler_pkg::*; (
    input  logic     clk24,
    input  logic     rst_n_i,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,
    input  src_pix_t src_pix_i,
    output out_pix_t out_pix_o,
    output logic     out_valid_o,
    input  logic     out_ready_i
);

    ctrl_t                 ctrl;
    logic                  overflow;
    logic                  line_start;
    wr_req_t               wr;
    logic                  group_done;
    logic                  done_group;
    logic                  group_free;
    logic                  free_group;
    logic                  rd_group;
    logic [PIX_ADDR_W-1:0] rd_addr;
    line_triple_t          rd_data;

    // --------------------
    // control block
    // --------------------

    scaler_apb_regs u_regs (
        .clk24        (clk24),
        .rst_n_i      (rst_n_i),
        .apb_req_i    (apb_req_i),
        .apb_rsp_o    (apb_rsp_o),
        .ctrl_o       (ctrl),
        .overflow_i   (overflow),
        .line_start_i (line_start)
    );

    // --------------------
    // datapath
    // --------------------

    // source lines into groups of three
    line_writer u_writer (
        .clk24        (clk24),
        .rst_n_i      (rst_n_i),
        .ctrl_i       (ctrl),
        .src_pix_i    (src_pix_i),
        .wr_o         (wr),
        .group_done_o (group_done),
        .done_group_o (done_group),
        .group_free_i (group_free),
        .free_group_i (free_group),
        .overflow_o   (overflow)
    );

    line_store u_store (
        .clk24      (clk24),
        .wr_i       (wr),
        .rd_group_i (rd_group),
        .rd_addr_i  (rd_addr),
        .rd_data_o  (rd_data)
    );

    // each group read as five display lines
    line_blender u_blender (
        .clk24        (clk24),
        .rst_n_i      (rst_n_i),
        .ctrl_i       (ctrl),
        .group_done_i (group_done),
        .done_group_i (done_group),
        .group_free_o (group_free),
        .free_group_o (free_group),
        .rd_group_o   (rd_group),
        .rd_addr_o    (rd_addr),
        .rd_data_i    (rd_data),
        .out_pix_o    (out_pix_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .line_start_o (line_start)
    );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD = 5;
    localparam int RESET_CYCLES = 8;

    // 10 ns pixel clock
    initial
    begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // reset released on a falling edge, away from the sampling edge
    initial
    begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/scaler_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module scaler_tb import scaler_pkg::*; ();

    localparam int GROUP_PIXELS = OUT_LINES_PER_GROUP * LINE_PIXELS;
    localparam int MAX_LINES = 9;
    // eight groups of output over all tests at 20 cycles per pixel plus margin
    localparam int WATCHDOG_CYCLES = GROUP_PIXELS * (1 + 2 + 3 + 2) * 20 + 2000;

    logic     clk24;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    src_pix_t src_pix;
    out_pix_t out_pix;
    logic     out_valid;
    logic     out_ready;

    color233_t src_mem [MAX_LINES][LINE_PIXELS];
    out_pix_t  exp_q[$];
    out_pix_t  got_q[$];
    int        lines_seen;
    int        pix_errors;
    int        reg_errors;
    int        flag_errors;
    int        other_errors;

    tb_clock u_clock (
        .clk_o   (clk24),
        .rst_n_o (rst_n)
    );

    scaler_top u_dut (
        .clk24       (clk24),
        .rst_n_i     (rst_n),
        .apb_req_i   (apb_req),
        .apb_rsp_o   (apb_rsp),
        .src_pix_i   (src_pix),
        .out_pix_o   (out_pix),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready)
    );

    // --------------------
    // compare tasks
    // --------------------

    task automatic compare_pix(input string name, input out_pix_t exp_v, input out_pix_t act_v);
        if (act_v !== exp_v)
        begin
            pix_errors++;
            $display("** Error at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic compare_reg(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (act_v !== exp_v)
        begin
            reg_errors++;
            $display("** Error at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
        begin
            flag_errors++;
            $display("** Error at %0t: %s expected %b actual %b", $time, name, exp_v, act_v);
        end
    endtask

    // --------------------
    // apb master
    // --------------------

    task automatic apb_transfer(input logic write, input logic [3:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge clk24);
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = write;
        apb_req.paddr = addr;
        apb_req.pwdata = wdata;
        @(negedge clk24);
        apb_req.penable = 1'b1;
        // response is sampled at the edge that ends the access cycle
        @(posedge clk24);
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        // no wait states are ever inserted
        compare_flag("pready", 1'b1, apb_rsp.pready);
        @(negedge clk24);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    // --------------------
    // reference model
    // --------------------

    // stored line of the group that feeds mix input k of output line oline
    function automatic int src_line(input int oline, input int k, input logic blend);
        if (!blend)
            // repeat table 1, 2, 2, 3, 3
            return (oline + 1) / 2;
        case (oline)
            0: return 0;
            // 3/1 of lines 1 and 2
            1: return (k == 3) ? 1 : 0;
            2: return 1;
            // 2/2 of lines 2 and 3
            3: return (k < 2) ? 1 : 2;
            default: return 2;
        endcase
    endfunction

    // five output lines of the group whose first source line is first
    task automatic add_group(input int first, input logic blend);
        color233_t  s;
        out_pix_t   e;
        logic [4:0] r;
        logic [4:0] g;
        logic [3:0] b;
        for (int o = 0; o < OUT_LINES_PER_GROUP; o++)
        begin
            for (int p = 0; p < LINE_PIXELS; p++)
            begin
                // rounding term
                r = 5'd1;
                g = 5'd1;
                b = 4'd1;
                for (int k = 0; k < 4; k++)
                begin
                    s = src_mem[first + src_line(o, k, blend)][p];
                    r = r + s.r;
                    g = g + s.g;
                    b = b + s.b;
                end
                e.sol = (p == 0);
                e.color.r = r;
                e.color.g = g;
                e.color.b = {b, 1'b0};
                exp_q.push_back(e);
            end
        end
    endtask

    // --------------------
    // stimulus and collection
    // --------------------

    task automatic make_lines(input int first, input int n);
        logic [31:0] rnd;
        for (int l = first; l < first + n; l++)
        begin
            for (int p = 0; p < LINE_PIXELS; p++)
            begin
                rnd = $urandom();
                src_mem[l][p] = rnd[7:0];
            end
        end
    endtask

    task automatic send_lines(input int first, input int n, input bit with_sof);
        for (int l = 0; l < n; l++)
        begin
            for (int p = 0; p < LINE_PIXELS; p++)
            begin
                @(negedge clk24);
                src_pix.valid = 1'b1;
                src_pix.sol = (p == 0);
                src_pix.sof = with_sof && (l == 0) && (p == 0);
                src_pix.color = src_mem[first + l][p];
            end
            // short horizontal blank
            repeat (2)
            begin
                @(negedge clk24);
                src_pix = '0;
            end
        end
    endtask

    // accepted output pixels in order
    always @(posedge clk24)
    begin
        if (rst_n && out_valid && out_ready)
        begin
            got_q.push_back(out_pix);
            if (out_pix.sol)
                lines_seen++;
        end
    end

    // extra cycles after the last pixel expose anything duplicated
    task automatic wait_output(input int n);
        while (got_q.size() < n)
            @(posedge clk24);
        repeat (20) @(posedge clk24);
    endtask

    task automatic check_output();
        int n;
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        if (got_q.size() != exp_q.size())
        begin
            other_errors++;
            $display("output pixel count wrong at %0t: expected %0d pixels, received %0d",
                     $time, exp_q.size(), got_q.size());
        end
        for (int i = 0; i < n; i++)
            compare_pix($sformatf("out_pix_o[%0d]", i), exp_q[i], got_q[i]);
        exp_q.delete();
        got_q.delete();
    endtask

    // --------------------
    // directed tests
    // --------------------

    task automatic test_registers();
        logic [31:0] data;
        logic        err;
        $display("test: registers");
        apb_read(ADDR_CTRL, data, err);
        compare_reg("CTRL", 32'h3, data);
        compare_flag("pslverr", 1'b0, err);
        apb_read(ADDR_STATUS, data, err);
        compare_reg("STATUS", 32'h0, data);
        apb_read(ADDR_LINE_COUNT, data, err);
        compare_reg("LINE_COUNT", 32'h0, data);
        apb_write(ADDR_CTRL, 32'h1, err);
        compare_flag("pslverr", 1'b0, err);
        apb_read(ADDR_CTRL, data, err);
        compare_reg("CTRL", 32'h1, data);
        apb_write(ADDR_CTRL, 32'h3, err);
        // nothing decoded at 0xc
        apb_read(4'hc, data, err);
        compare_flag("pslverr", 1'b1, err);
        apb_write(4'hc, 32'h0, err);
        compare_flag("pslverr", 1'b1, err);
    endtask

    task automatic test_blend();
        $display("test: blend table");
        make_lines(0, 3);
        add_group(0, 1'b1);
        send_lines(0, 3, 1'b1);
        wait_output(GROUP_PIXELS);
        check_output();
    endtask

    task automatic test_repeat();
        logic err;
        $display("test: repeat table");
        apb_write(ADDR_CTRL, 32'h1, err);
        make_lines(0, 6);
        add_group(0, 1'b0);
        add_group(3, 1'b0);
        send_lines(0, 6, 1'b1);
        wait_output(2 * GROUP_PIXELS);
        check_output();
        apb_write(ADDR_CTRL, 32'h3, err);
    endtask

    task automatic test_backpressure();
        logic [31:0] rnd;
        logic [31:0] data;
        logic        err;
        bit          done;
        $display("test: back-pressure");
        done = 1'b0;
        make_lines(0, 9);
        for (int g = 0; g < 3; g++)
            add_group(3 * g, 1'b1);
        fork
            begin
                for (int g = 0; g < 3; g++)
                begin
                    // the third group reuses A which has to drain first
                    while (got_q.size() < (g - 1) * GROUP_PIXELS)
                        @(posedge clk24);
                    send_lines(3 * g, 3, g == 0);
                end
                while (got_q.size() < exp_q.size())
                    @(posedge clk24);
                done = 1'b1;
            end
            begin
                while (!done)
                begin
                    @(negedge clk24);
                    rnd = $urandom();
                    out_ready = rnd[0];
                end
            end
        join
        @(negedge clk24);
        out_ready = 1'b1;
        wait_output(3 * GROUP_PIXELS);
        check_output();
        // input was paced so no line may have been dropped
        apb_read(ADDR_STATUS, data, err);
        compare_reg("STATUS", 32'h0, data);
    endtask

    task automatic test_overflow();
        logic [31:0] data;
        logic        err;
        $display("test: overflow");
        @(negedge clk24);
        out_ready = 1'b0;
        make_lines(0, 9);
        // lines 7 to 9 find group A still full
        add_group(0, 1'b1);
        add_group(3, 1'b1);
        send_lines(0, 9, 1'b1);
        @(negedge clk24);
        out_ready = 1'b1;
        wait_output(2 * GROUP_PIXELS);
        check_output();
        apb_read(ADDR_STATUS, data, err);
        compare_reg("STATUS", 32'h1, data);
        apb_write(ADDR_STATUS, 32'h1, err);
        apb_read(ADDR_STATUS, data, err);
        compare_reg("STATUS", 32'h0, data);
    endtask

    task automatic test_line_count();
        logic [31:0] data;
        logic        err;
        $display("test: line count");
        apb_read(ADDR_LINE_COUNT, data, err);
        compare_reg("LINE_COUNT", 32'(lines_seen), data);
    endtask

    // --------------------
    // run control
    // --------------------

    initial
    begin
        int total;
        void'($urandom(32'hb1ce));
        apb_req = '0;
        src_pix = '0;
        out_ready = 1'b1;
        lines_seen = 0;
        pix_errors = 0;
        reg_errors = 0;
        flag_errors = 0;
        other_errors = 0;
        wait (rst_n === 1'b1);
        @(negedge clk24);
        test_registers();
        test_blend();
        test_repeat();
        test_backpressure();
        test_overflow();
        test_line_count();
        total = pix_errors + reg_errors + flag_errors + other_errors;
        $display("errors: pixel %0d, register %0d, flag %0d, other %0d, total %0d",
                 pix_errors, reg_errors, flag_errors, other_errors, total);
        if (total == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // watchdog for a stuck pipeline or a lost group
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk24);
        $display("watchdog expired at %0t, output did not arrive in time", $time);
        $display("errors: pixel %0d, register %0d, flag %0d, other %0d",
                 pix_errors, reg_errors, flag_errors, other_errors);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
src/scaler_pkg.sv
src/scaler_apb_regs.sv
src/line_writer.sv
src/line_store.sv
src/line_blender.sv
src/scaler_top.sv
tb/tb_clock.sv
tb/scaler_tb.sv
